/* pext_op_pkg.sv */
// Packed-SIMD operation encodings
// Opcodes, result sources and compare kinds shared by decoder and datapath

package pext_op_pkg;

  // Upper four bits name the operation group, lower two the lane width
  // (0 = 8-bit, 1 = 16-bit, 2 = 32-bit)
  typedef enum logic [5:0] {
    OP_ADD8    = 6'h00, OP_ADD16    = 6'h01, OP_ADD32  = 6'h02,
    OP_SUB8    = 6'h04, OP_SUB16    = 6'h05, OP_SUB32  = 6'h06,
    OP_KADD8   = 6'h08, OP_KADD16   = 6'h09, OP_KADD32 = 6'h0a,
    OP_KSUB8   = 6'h0c, OP_KSUB16   = 6'h0d, OP_KSUB32 = 6'h0e,
    OP_UKADD8  = 6'h10, OP_UKADD16  = 6'h11,
    OP_UKSUB8  = 6'h14, OP_UKSUB16  = 6'h15,
    OP_RADD8   = 6'h18, OP_RADD16   = 6'h19,
    OP_URADD8  = 6'h1c, OP_URADD16  = 6'h1d,
    OP_RSUB8   = 6'h20, OP_RSUB16   = 6'h21,
    OP_CMPEQ8  = 6'h24, OP_CMPEQ16  = 6'h25,
    OP_SCMPLT8 = 6'h28, OP_SCMPLT16 = 6'h29,
    OP_UCMPLT8 = 6'h2c, OP_UCMPLT16 = 6'h2d,
    OP_SMIN8   = 6'h30, OP_SMIN16   = 6'h31,
    OP_SMAX8   = 6'h34, OP_SMAX16   = 6'h35,
    OP_UMIN8   = 6'h38, OP_UMIN16   = 6'h39,
    OP_UMAX8   = 6'h3c, OP_UMAX16   = 6'h3d
  } pext_op_e;

  // Which datapath output feeds the result register
  typedef enum logic [2:0] {
    RES_WRAP   = 3'd0,
    RES_SAT    = 3'd1,
    RES_HALVE  = 3'd2,
    RES_CMP    = 3'd3,
    RES_MINMAX = 3'd4
  } result_kind_e;

  typedef enum logic [1:0] {
    CMP_EQ  = 2'd0,
    CMP_LT  = 2'd1,
    CMP_MIN = 2'd2,
    CMP_MAX = 2'd3
  } cmp_kind_e;

endpackage

/* simd_lane_pkg.sv */
// SIMD lane geometry
// Element widths, lane word types and saturation limits

package simd_lane_pkg;

  // Encoding matches the low two opcode bits
  typedef enum logic [1:0] {
    EW_8  = 2'd0,
    EW_16 = 2'd1,
    EW_32 = 2'd2
  } elem_width_e;

  typedef logic [31:0] lane_word_t;

  // Per byte: [7:0] sum byte, [8] carry out or lane sign
  typedef logic [3:0][8:0] lane_sum_t;

  // One flag per byte lane
  typedef logic [3:0] lane_flags_t;

  //////////////////////////////////////////////////
  // Saturation limits
  //////////////////////////////////////////////////
  localparam logic [7:0]  SAT_S8_MIN  = 8'h80;
  localparam logic [7:0]  SAT_S8_MAX  = 8'h7f;
  localparam logic [15:0] SAT_S16_MIN = 16'h8000;
  localparam logic [15:0] SAT_S16_MAX = 16'h7fff;
  localparam logic [31:0] SAT_S32_MIN = 32'h8000_0000;
  localparam logic [31:0] SAT_S32_MAX = 32'h7fff_ffff;
  localparam logic [7:0]  SAT_U8_MAX  = 8'hff;

endpackage

/* pext_op_decoder.sv */
// Packed operation decoder
// Maps an opcode to lane width, signedness, subtract and result selection

module pext_op_decoder (
  input  pext_op_pkg::pext_op_e       op_i,
  output simd_lane_pkg::elem_width_e  width_o,
  output logic                        signed_ops_o,
  output logic                        subtract_o,
  output pext_op_pkg::result_kind_e   res_kind_o,
  output pext_op_pkg::cmp_kind_e      cmp_kind_o
);

  import pext_op_pkg::*;
  import simd_lane_pkg::*;

  // Width code sits in the low opcode bits
  assign width_o = elem_width_e'(op_i[1:0]);

  always_comb begin
    signed_ops_o = 1'b0;
    subtract_o   = 1'b0;
    res_kind_o   = RES_WRAP;
    cmp_kind_o   = CMP_EQ;

    unique case (op_i)
      OP_ADD8, OP_ADD16, OP_ADD32: begin
        res_kind_o = RES_WRAP;
      end
      OP_SUB8, OP_SUB16, OP_SUB32: begin
        subtract_o = 1'b1;
      end

      //////////////////////////////////////////////////
      // Saturating
      //////////////////////////////////////////////////
      OP_KADD8, OP_KADD16, OP_KADD32: begin
        signed_ops_o = 1'b1;
        res_kind_o   = RES_SAT;
      end
      OP_KSUB8, OP_KSUB16, OP_KSUB32: begin
        signed_ops_o = 1'b1;
        subtract_o   = 1'b1;
        res_kind_o   = RES_SAT;
      end
      OP_UKADD8, OP_UKADD16: begin
        res_kind_o = RES_SAT;
      end
      OP_UKSUB8, OP_UKSUB16: begin
        subtract_o = 1'b1;
        res_kind_o = RES_SAT;
      end

      // Halving
      OP_RADD8, OP_RADD16: begin
        signed_ops_o = 1'b1;
        res_kind_o   = RES_HALVE;
      end
      OP_URADD8, OP_URADD16: begin
        res_kind_o = RES_HALVE;
      end
      OP_RSUB8, OP_RSUB16: begin
        signed_ops_o = 1'b1;
        subtract_o   = 1'b1;
        res_kind_o   = RES_HALVE;
      end

      //////////////////////////////////////////////////
      // Compare and min/max, all on the A - B difference
      //////////////////////////////////////////////////
      OP_CMPEQ8, OP_CMPEQ16: begin
        subtract_o = 1'b1;
        res_kind_o = RES_CMP;
        cmp_kind_o = CMP_EQ;
      end
      OP_SCMPLT8, OP_SCMPLT16, OP_UCMPLT8, OP_UCMPLT16: begin
        signed_ops_o = (op_i == OP_SCMPLT8) || (op_i == OP_SCMPLT16);
        subtract_o   = 1'b1;
        res_kind_o   = RES_CMP;
        cmp_kind_o   = CMP_LT;
      end
      OP_SMIN8, OP_SMIN16, OP_UMIN8, OP_UMIN16: begin
        signed_ops_o = (op_i == OP_SMIN8) || (op_i == OP_SMIN16);
        subtract_o   = 1'b1;
        res_kind_o   = RES_MINMAX;
        cmp_kind_o   = CMP_MIN;
      end
      OP_SMAX8, OP_SMAX16, OP_UMAX8, OP_UMAX16: begin
        signed_ops_o = (op_i == OP_SMAX8) || (op_i == OP_SMAX16);
        subtract_o   = 1'b1;
        res_kind_o   = RES_MINMAX;
        cmp_kind_o   = CMP_MAX;
      end
      default: ;
    endcase
  end

endmodule

/* simd_lane_adder.sv */
// Lane-segmented adder
// Four 9-bit byte adders whose carry chain breaks at lane boundaries

module simd_lane_adder (
  input  simd_lane_pkg::lane_word_t   operand_a_i,
  input  simd_lane_pkg::lane_word_t   operand_b_i,
  input  simd_lane_pkg::elem_width_e  width_i,
  input  logic                        signed_ops_i,
  input  logic                        subtract_i,
  output simd_lane_pkg::lane_sum_t    sums_o,
  output simd_lane_pkg::lane_word_t   wrap_result_o
);

  import simd_lane_pkg::*;

  lane_flags_t lane_start;
  lane_flags_t lane_top;

  // Bytes that begin and end a lane
  always_comb begin
    unique case (width_i)
      EW_8: begin
        lane_start = 4'b1111;
        lane_top   = 4'b1111;
      end
      EW_16: begin
        lane_start = 4'b0101;
        lane_top   = 4'b1010;
      end
      default: begin
        lane_start = 4'b0001;
        lane_top   = 4'b1000;
      end
    endcase
  end

  always_comb begin
    logic       carry;
    logic       cin;
    logic       ext_a;
    logic       ext_b;
    logic [7:0] b_byte;

    carry = 1'b0;
    for (int b = 0; b < 4; b++) begin
      b_byte = subtract_i ? ~operand_b_i[8*b +: 8] : operand_b_i[8*b +: 8];
      // Sign extend only at a lane top, so bit 8 there is the true sign
      ext_a  = lane_top[b] & signed_ops_i & operand_a_i[8*b+7];
      ext_b  = lane_top[b] & signed_ops_i & b_byte[7];
      // Two's complement +1 enters at the lane start
      cin    = lane_start[b] ? subtract_i : carry;
      sums_o[b] = {ext_a, operand_a_i[8*b +: 8]} + {ext_b, b_byte} + {8'h00, cin};
      carry  = sums_o[b][8];
    end
  end

  assign wrap_result_o = {sums_o[3][7:0], sums_o[2][7:0], sums_o[1][7:0], sums_o[0][7:0]};

endmodule

/* simd_saturate.sv */
// Saturating and halving lane results
// Clamps overflowing lanes to package limits and forms the averaged lanes

module simd_saturate (
  input  simd_lane_pkg::lane_sum_t    sums_i,
  input  simd_lane_pkg::elem_width_e  width_i,
  input  logic                        signed_ops_i,
  input  logic                        subtract_i,
  output simd_lane_pkg::lane_word_t   sat_result_o,
  output simd_lane_pkg::lane_word_t   halve_result_o,
  output simd_lane_pkg::lane_flags_t  lane_ov_o
);

  import simd_lane_pkg::*;

  lane_word_t  wrap_word;
  lane_flags_t byte_ov;
  lane_flags_t top_bit;

  assign wrap_word = {sums_i[3][7:0], sums_i[2][7:0], sums_i[1][7:0], sums_i[0][7:0]};

  always_comb begin
    for (int b = 0; b < 4; b++) begin
      // Signed: sign and extra bit disagree. Unsigned: carry vs. borrow
      byte_ov[b] = signed_ops_i ? (sums_i[b][8] ^ sums_i[b][7]) : (sums_i[b][8] ^ subtract_i);
      // Unsigned subtract leaves an inverted borrow in bit 8
      top_bit[b] = sums_i[b][8] ^ (~signed_ops_i & subtract_i);
    end
  end

  // Spread the top-byte flag over the whole lane
  always_comb begin
    unique case (width_i)
      EW_8:    lane_ov_o = byte_ov;
      EW_16:   lane_ov_o = {{2{byte_ov[3]}}, {2{byte_ov[1]}}};
      default: lane_ov_o = {4{byte_ov[3]}};
    endcase
  end

  //////////////////////////////////////////////////
  // Clamp
  //////////////////////////////////////////////////
  always_comb begin
    sat_result_o = wrap_word;
    unique case (width_i)
      EW_8: begin
        for (int b = 0; b < 4; b++) begin
          if (lane_ov_o[b]) begin
            sat_result_o[8*b +: 8] = signed_ops_i ?
                (sums_i[b][8] ? SAT_S8_MIN : SAT_S8_MAX) :
                (subtract_i ? 8'h00 : SAT_U8_MAX);
          end
        end
      end
      EW_16: begin
        for (int h = 0; h < 2; h++) begin
          if (lane_ov_o[2*h+1]) begin
            sat_result_o[16*h +: 16] = signed_ops_i ?
                (sums_i[2*h+1][8] ? SAT_S16_MIN : SAT_S16_MAX) :
                (subtract_i ? 16'h0000 : {2{SAT_U8_MAX}});
          end
        end
      end
      default: begin
        if (lane_ov_o[3]) begin
          sat_result_o = signed_ops_i ? (sums_i[3][8] ? SAT_S32_MIN : SAT_S32_MAX) :
                                        (subtract_i ? 32'h0 : {4{SAT_U8_MAX}});
        end
      end
    endcase
  end

  // Halving drops the lane LSB, rounding toward minus infinity
  always_comb begin
    unique case (width_i)
      EW_8: begin
        for (int b = 0; b < 4; b++) begin
          halve_result_o[8*b +: 8] = {top_bit[b], sums_i[b][7:1]};
        end
      end
      EW_16: begin
        halve_result_o = {top_bit[3], sums_i[3][7:0], sums_i[2][7:1],
                          top_bit[1], sums_i[1][7:0], sums_i[0][7:1]};
      end
      default: halve_result_o = {top_bit[3], wrap_word[31:1]};
    endcase
  end

endmodule

/* simd_compare.sv */
// Lane comparison and min/max
// Builds equal and less-than lane masks from the adder difference

module simd_compare (
  input  simd_lane_pkg::lane_word_t   operand_a_i,
  input  simd_lane_pkg::lane_word_t   operand_b_i,
  input  simd_lane_pkg::lane_sum_t    sums_i,
  input  simd_lane_pkg::elem_width_e  width_i,
  input  logic                        signed_ops_i,
  input  pext_op_pkg::cmp_kind_e      cmp_kind_i,
  output simd_lane_pkg::lane_word_t   cmp_result_o,
  output simd_lane_pkg::lane_word_t   minmax_result_o
);

  import simd_lane_pkg::*;
  import pext_op_pkg::*;

  lane_flags_t byte_zero;
  lane_flags_t byte_lt;
  lane_flags_t lane_eq;
  lane_flags_t lane_lt;
  lane_flags_t lane_mask;

  always_comb begin
    for (int b = 0; b < 4; b++) begin
      byte_zero[b] = (sums_i[b][7:0] == 8'h00);
      // Same sign: the difference cannot overflow, so its sign decides
      if (operand_a_i[8*b+7] == operand_b_i[8*b+7]) begin
        byte_lt[b] = sums_i[b][7];
      end else begin
        byte_lt[b] = operand_a_i[8*b+7] ^ ~signed_ops_i;
      end
    end
  end

  //////////////////////////////////////////////////
  // Combine bytes into lanes
  //////////////////////////////////////////////////
  always_comb begin
    unique case (width_i)
      EW_8: begin
        lane_eq = byte_zero;
        lane_lt = byte_lt;
      end
      EW_16: begin
        lane_eq = {{2{&byte_zero[3:2]}}, {2{&byte_zero[1:0]}}};
        lane_lt = {{2{byte_lt[3]}}, {2{byte_lt[1]}}};
      end
      default: begin
        lane_eq = {4{&byte_zero}};
        lane_lt = {4{byte_lt[3]}};
      end
    endcase
  end

  // For min/max a set bit picks operand A
  always_comb begin
    unique case (cmp_kind_i)
      CMP_EQ:  lane_mask = lane_eq;
      CMP_MAX: lane_mask = ~lane_lt;
      default: lane_mask = lane_lt;
    endcase
  end

  always_comb begin
    for (int b = 0; b < 4; b++) begin
      cmp_result_o[8*b +: 8]    = {8{lane_mask[b]}};
      minmax_result_o[8*b +: 8] = lane_mask[b] ? operand_a_i[8*b +: 8] : operand_b_i[8*b +: 8];
    end
  end

endmodule

/* simd_result_stage.sv */
// Result select and output register
// Picks the datapath result by kind and registers it with valid and overflow

module simd_result_stage (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        op_valid_i,
  input  pext_op_pkg::result_kind_e   res_kind_i,
  input  simd_lane_pkg::lane_word_t   wrap_result_i,
  input  simd_lane_pkg::lane_word_t   sat_result_i,
  input  simd_lane_pkg::lane_word_t   halve_result_i,
  input  simd_lane_pkg::lane_word_t   cmp_result_i,
  input  simd_lane_pkg::lane_word_t   minmax_result_i,
  input  simd_lane_pkg::lane_flags_t  lane_ov_i,
  output simd_lane_pkg::lane_word_t   result_o,
  output logic                        valid_o,
  output logic                        set_ov_o
);

  import pext_op_pkg::*;
  import simd_lane_pkg::*;

  lane_word_t result_d;
  logic       set_ov_d;

  always_comb begin
    unique case (res_kind_i)
      RES_SAT:    result_d = sat_result_i;
      RES_HALVE:  result_d = halve_result_i;
      RES_CMP:    result_d = cmp_result_i;
      RES_MINMAX: result_d = minmax_result_i;
      default:    result_d = wrap_result_i;
    endcase
  end

  // Only saturating ops report overflow
  assign set_ov_d = (res_kind_i == RES_SAT) && (|lane_ov_i);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      result_o <= '0;
      valid_o  <= 1'b0;
      set_ov_o <= 1'b0;
    end else begin
      valid_o  <= op_valid_i;
      set_ov_o <= op_valid_i & set_ov_d;
      // Result holds through idle cycles
      if (op_valid_i) begin
        result_o <= result_d;
      end
    end
  end

endmodule

/* simd_alu_top.sv */
// Packed-SIMD arithmetic unit
// One-stage pipeline for lane add/sub, saturate, halve, compare and min/max

module simd_alu_top (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       op_valid_i,
  input  pext_op_pkg::pext_op_e      op_i,
  input  simd_lane_pkg::lane_word_t  operand_a_i,
  input  simd_lane_pkg::lane_word_t  operand_b_i,
  output simd_lane_pkg::lane_word_t  result_o,
  output logic                       valid_o,
  output logic                       set_ov_o
);

  import pext_op_pkg::*;
  import simd_lane_pkg::*;

  elem_width_e  width;
  logic         signed_ops;
  logic         subtract;
  result_kind_e res_kind;
  cmp_kind_e    cmp_kind;

  lane_sum_t    sums;
  lane_word_t   wrap_result;
  lane_word_t   sat_result;
  lane_word_t   halve_result;
  lane_word_t   cmp_result;
  lane_word_t   minmax_result;
  lane_flags_t  lane_ov;

  pext_op_decoder pext_op_decoder_inst (
    .op_i         (op_i),
    .width_o      (width),
    .signed_ops_o (signed_ops),
    .subtract_o   (subtract),
    .res_kind_o   (res_kind),
    .cmp_kind_o   (cmp_kind)
  );

  //////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////
  simd_lane_adder simd_lane_adder_inst (
    .operand_a_i   (operand_a_i),
    .operand_b_i   (operand_b_i),
    .width_i       (width),
    .signed_ops_i  (signed_ops),
    .subtract_i    (subtract),
    .sums_o        (sums),
    .wrap_result_o (wrap_result)
  );

  simd_saturate simd_saturate_inst (
    .sums_i         (sums),
    .width_i        (width),
    .signed_ops_i   (signed_ops),
    .subtract_i     (subtract),
    .sat_result_o   (sat_result),
    .halve_result_o (halve_result),
    .lane_ov_o      (lane_ov)
  );

  simd_compare simd_compare_inst (
    .operand_a_i     (operand_a_i),
    .operand_b_i     (operand_b_i),
    .sums_i          (sums),
    .width_i         (width),
    .signed_ops_i    (signed_ops),
    .cmp_kind_i      (cmp_kind),
    .cmp_result_o    (cmp_result),
    .minmax_result_o (minmax_result)
  );

  simd_result_stage simd_result_stage_inst (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .op_valid_i      (op_valid_i),
    .res_kind_i      (res_kind),
    .wrap_result_i   (wrap_result),
    .sat_result_i    (sat_result),
    .halve_result_i  (halve_result),
    .cmp_result_i    (cmp_result),
    .minmax_result_i (minmax_result),
    .lane_ov_i       (lane_ov),
    .result_o        (result_o),
    .valid_o         (valid_o),
    .set_ov_o        (set_ov_o)
  );

endmodule

/* simd_alu_sva.sv */
// Handshake assertions for the packed-SIMD unit
// Bound into the top level to watch valid, overflow and reset timing

module simd_alu_sva (
  input logic                       clk_i,
  input logic                       rst_n_i,
  input logic                       op_valid_i,
  input simd_lane_pkg::lane_word_t  result_o,
  input logic                       valid_o,
  input logic                       set_ov_o
);
  timeunit 1ns;
  timeprecision 1ps;

  // One-cycle pipeline
  valid_follows_op: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    valid_o == $past(op_valid_i))
    else $error("valid_o does not follow op_valid_i by one cycle");

  ov_needs_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    set_ov_o |-> valid_o)
    else $error("set_ov_o high without valid_o");

  reset_clears_outputs: assert property (@(posedge clk_i)
    $rose(rst_n_i) |-> (!valid_o && !set_ov_o && (result_o == '0)))
    else $error("outputs not zero right after reset");

endmodule

bind simd_alu_top simd_alu_sva simd_alu_sva_inst (
  .clk_i      (clk_i),
  .rst_n_i    (rst_n_i),
  .op_valid_i (op_valid_i),
  .result_o   (result_o),
  .valid_o    (valid_o),
  .set_ov_o   (set_ov_o)
);

/* tb_simd_alu.sv */
// Directed testbench for the packed-SIMD arithmetic unit
// Checks wrap, saturate, halve, compare, min/max and back-to-back timing

module tb_simd_alu;
  timeunit 1ns;
  timeprecision 1ps;

  import pext_op_pkg::*;
  import simd_lane_pkg::*;

  localparam int NUM_TESTS    = 6;
  localparam int OPS_PER_TEST = 64;
  // Two clock cycles per operation, plus reset and margin
  localparam int TIMEOUT_NS   = NUM_TESTS * OPS_PER_TEST * 2 * 10 + 500;

  logic       clk = 1'b0;
  logic       rst_n;
  logic       op_valid;
  pext_op_e   op;
  lane_word_t operand_a;
  lane_word_t operand_b;
  lane_word_t result;
  logic       valid;
  logic       set_ov;

  int errors = 0;
  int checks = 0;
  int tests_run = 0;

  always #5 clk = ~clk;

  simd_alu_top simd_alu_top_inst (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .op_valid_i  (op_valid),
    .op_i        (op),
    .operand_a_i (operand_a),
    .operand_b_i (operand_b),
    .result_o    (result),
    .valid_o     (valid),
    .set_ov_o    (set_ov)
  );

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////
  function automatic int lane_bits(input pext_op_e code);
    case (code)
      OP_ADD32, OP_SUB32, OP_KADD32, OP_KSUB32: return 32;
      OP_ADD16, OP_SUB16, OP_KADD16, OP_KSUB16, OP_UKADD16, OP_UKSUB16,
      OP_RADD16, OP_URADD16, OP_RSUB16, OP_CMPEQ16, OP_SCMPLT16, OP_UCMPLT16,
      OP_SMIN16, OP_SMAX16, OP_UMIN16, OP_UMAX16: return 16;
      default: return 8;
    endcase
  endfunction

  function automatic longint clamp_lane(input longint v, input longint lo, input longint hi,
                                        output logic hit);
    hit = (v < lo) || (v > hi);
    if (v < lo) return lo;
    if (v > hi) return hi;
    return v;
  endfunction

  // One lane from integer arithmetic, result masked to the lane width
  function automatic longint lane_ref(input pext_op_e code, input longint ua, input longint ub,
                                      input int n, output logic ov);
    longint umax;
    longint sa;
    longint sb;
    longint smin;
    longint smax;
    longint r;

    ov   = 1'b0;
    r    = 0;
    umax = (longint'(1) << n) - 1;
    sa   = (ua > (umax >> 1)) ? ua - umax - 1 : ua;
    sb   = (ub > (umax >> 1)) ? ub - umax - 1 : ub;
    case (n)
      8: begin
        smin = longint'($signed(SAT_S8_MIN));
        smax = longint'($signed(SAT_S8_MAX));
      end
      16: begin
        smin = longint'($signed(SAT_S16_MIN));
        smax = longint'($signed(SAT_S16_MAX));
      end
      default: begin
        smin = longint'($signed(SAT_S32_MIN));
        smax = longint'($signed(SAT_S32_MAX));
      end
    endcase
    case (code)
      OP_ADD8, OP_ADD16, OP_ADD32:        r = ua + ub;
      OP_SUB8, OP_SUB16, OP_SUB32:        r = ua - ub;
      OP_KADD8, OP_KADD16, OP_KADD32:     r = clamp_lane(sa + sb, smin, smax, ov);
      OP_KSUB8, OP_KSUB16, OP_KSUB32:     r = clamp_lane(sa - sb, smin, smax, ov);
      OP_UKADD8, OP_UKADD16:              r = clamp_lane(ua + ub, 0, umax, ov);
      OP_UKSUB8, OP_UKSUB16:              r = clamp_lane(ua - ub, 0, umax, ov);
      // Arithmetic shift of the full sum gives floor
      OP_RADD8, OP_RADD16:                r = (sa + sb) >>> 1;
      OP_URADD8, OP_URADD16:              r = (ua + ub) >>> 1;
      OP_RSUB8, OP_RSUB16:                r = (sa - sb) >>> 1;
      OP_CMPEQ8, OP_CMPEQ16:              r = (ua == ub) ? umax : 0;
      OP_SCMPLT8, OP_SCMPLT16:            r = (sa < sb) ? umax : 0;
      OP_UCMPLT8, OP_UCMPLT16:            r = (ua < ub) ? umax : 0;
      OP_SMIN8, OP_SMIN16:                r = (sa < sb) ? ua : ub;
      OP_SMAX8, OP_SMAX16:                r = (sa < sb) ? ub : ua;
      OP_UMIN8, OP_UMIN16:                r = (ua < ub) ? ua : ub;
      OP_UMAX8, OP_UMAX16:                r = (ua < ub) ? ub : ua;
      default:                            r = 0;
    endcase
    return r & umax;
  endfunction

  function automatic void compute_expected(input pext_op_e code, input lane_word_t a,
                                           input lane_word_t b, output lane_word_t res,
                                           output logic ov);
    int     n;
    longint mask;
    longint ua;
    longint ub;
    longint acc;
    logic   lane_ov;

    n    = lane_bits(code);
    mask = (longint'(1) << n) - 1;
    acc  = 0;
    ov   = 1'b0;
    for (int l = 0; l < 32 / n; l++) begin
      ua  = (longint'(a) >> (l * n)) & mask;
      ub  = (longint'(b) >> (l * n)) & mask;
      acc = acc | (lane_ref(code, ua, ub, n, lane_ov) << (l * n));
      ov  = ov | lane_ov;
    end
    res = acc[31:0];
  endfunction

  //////////////////////////////////////////////////
  // Compare and drive helpers
  //////////////////////////////////////////////////
  task automatic check_word(input string name, input lane_word_t got, input lane_word_t exp);
    checks++;
    if (got !== exp) begin
      $display("Error: time %0t signal %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      $display("Error: time %0t signal %s got %b expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  // Issue one operation, then check it one cycle later
  task automatic run_op(input pext_op_e code, input lane_word_t a, input lane_word_t b);
    lane_word_t exp_res;
    logic       exp_ov;

    compute_expected(code, a, b, exp_res, exp_ov);
    @(posedge clk);
    op_valid  <= 1'b1;
    op        <= code;
    operand_a <= a;
    operand_b <= b;
    @(posedge clk);
    op_valid  <= 1'b0;
    @(negedge clk);
    check_flag("valid_o", valid, 1'b1);
    check_word("result_o", result, exp_res);
    check_flag("set_ov_o", set_ov, exp_ov);
  endtask

  task automatic report_test(input string name, input int err_start);
    tests_run++;
    $display("%-14s %s with %0d errors", name, (errors == err_start) ? "ok" : "broken",
             errors - err_start);
  endtask

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////
  task automatic test_wrap();
    pext_op_e ops [6] = '{OP_ADD8, OP_ADD16, OP_ADD32, OP_SUB8, OP_SUB16, OP_SUB32};
    int       err_start;

    err_start = errors;
    foreach (ops[i]) begin
      // Carries out of every byte must stay in their lane
      run_op(ops[i], 32'hffff_ffff, 32'h0101_0101);
      repeat (7) run_op(ops[i], $urandom(), $urandom());
    end
    report_test("wrap add/sub", err_start);
  endtask

  task automatic test_saturate();
    pext_op_e ops [10] = '{OP_KADD8, OP_KADD16, OP_KADD32, OP_KSUB8, OP_KSUB16, OP_KSUB32,
                           OP_UKADD8, OP_UKADD16, OP_UKSUB8, OP_UKSUB16};
    int       err_start;

    err_start = errors;
    foreach (ops[i]) begin
      run_op(ops[i], 32'h7fff_ffff, 32'h7f01_0101);
      run_op(ops[i], 32'h8080_8000, 32'h8080_8000);
      run_op(ops[i], 32'h8000_0000, 32'h7fff_0001);
      // In range for every width and signedness
      run_op(ops[i], 32'h1020_3040, 32'h0102_0304);
      repeat (2) run_op(ops[i], $urandom(), $urandom());
    end
    report_test("saturate", err_start);
  endtask

  task automatic test_halve();
    pext_op_e ops [6] = '{OP_RADD8, OP_RADD16, OP_URADD8, OP_URADD16, OP_RSUB8, OP_RSUB16};
    int       err_start;

    err_start = errors;
    foreach (ops[i]) begin
      run_op(ops[i], 32'hffff_ffff, 32'h0101_0101);
      run_op(ops[i], 32'h8080_8000, 32'h8080_8000);
      repeat (6) run_op(ops[i], $urandom(), $urandom());
    end
    report_test("halve", err_start);
  endtask

  task automatic test_compare();
    pext_op_e   ops [6] = '{OP_CMPEQ8, OP_CMPEQ16, OP_SCMPLT8, OP_SCMPLT16,
                            OP_UCMPLT8, OP_UCMPLT16};
    lane_word_t a;
    int         err_start;

    err_start = errors;
    foreach (ops[i]) begin
      a = $urandom();
      run_op(ops[i], a, a);
      run_op(ops[i], a, a ^ 32'h0001_0000);
      // Mixed signs in every lane
      run_op(ops[i], 32'h807f_01ff, 32'h7f80_ff01);
      repeat (5) run_op(ops[i], $urandom(), $urandom());
    end
    report_test("compare", err_start);
  endtask

  task automatic test_minmax();
    pext_op_e   ops [8] = '{OP_SMIN8, OP_SMIN16, OP_SMAX8, OP_SMAX16,
                            OP_UMIN8, OP_UMIN16, OP_UMAX8, OP_UMAX16};
    lane_word_t a;
    int         err_start;

    err_start = errors;
    foreach (ops[i]) begin
      a = $urandom();
      run_op(ops[i], a, a);
      run_op(ops[i], 32'h807f_01ff, 32'h7f80_ff01);
      repeat (4) run_op(ops[i], $urandom(), $urandom());
    end
    report_test("min/max", err_start);
  endtask

  task automatic test_back_to_back();
    pext_op_e   ops [8] = '{OP_ADD8, OP_KADD16, OP_RSUB8, OP_SCMPLT16,
                            OP_UMAX8, OP_UKSUB16, OP_SUB32, OP_CMPEQ8};
    lane_word_t exp_res [8];
    logic       exp_ov [8];
    lane_word_t a;
    lane_word_t b;
    int         err_start;

    err_start = errors;
    for (int i = 0; i <= 8; i++) begin
      @(posedge clk);
      if (i < 8) begin
        a = $urandom();
        b = $urandom();
        compute_expected(ops[i], a, b, exp_res[i], exp_ov[i]);
        op_valid  <= 1'b1;
        op        <= ops[i];
        operand_a <= a;
        operand_b <= b;
      end else begin
        op_valid <= 1'b0;
      end
      @(negedge clk);
      if (i > 0) begin
        check_flag("valid_o", valid, 1'b1);
        check_word("result_o", result, exp_res[i-1]);
        check_flag("set_ov_o", set_ov, exp_ov[i-1]);
      end
    end
    // Idle cycle keeps the last result
    @(negedge clk);
    check_flag("valid_o", valid, 1'b0);
    check_word("result_o", result, exp_res[7]);
    check_flag("set_ov_o", set_ov, 1'b0);
    report_test("back-to-back", err_start);
  endtask

  initial begin
    #(TIMEOUT_NS);
    $display("Watchdog expired before the tests finished");
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    void'($urandom(98319));
    rst_n     = 1'b0;
    op_valid  = 1'b0;
    op        = OP_ADD8;
    operand_a = '0;
    operand_b = '0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_flag("valid_o", valid, 1'b0);
    check_word("result_o", result, '0);
    check_flag("set_ov_o", set_ov, 1'b0);

    test_wrap();
    test_saturate();
    test_halve();
    test_compare();
    test_minmax();
    test_back_to_back();

    $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* src.f */
pext_op_pkg.sv
simd_lane_pkg.sv
pext_op_decoder.sv
simd_lane_adder.sv
simd_saturate.sv
simd_compare.sv
simd_result_stage.sv
simd_alu_top.sv
simd_alu_sva.sv
tb_simd_alu.sv

/* run.sh */
#!/bin/sh
# Build and run the SIMD unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_simd_alu -f src.f

output=$(./obj_dir/Vtb_simd_alu 2>&1) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -q "TEST RESULT: PASS"; then
  exit 0
fi
echo "Simulation did not pass"
exit 1
